// ==== usb_dump_pkg.sv ====
`default_nettype none

package usb_dump_pkg;

    // widths that carry a meaning
    typedef logic [7:0]  byte_t;       // ascii character or buffer data byte
    typedef logic [9:0]  buf_addr_t;   // byte address, 1024 bytes
    typedef logic [12:0] bit_addr_t;   // [12:3] byte, [2:0] bit, msb first
    typedef logic [6:0]  rom_addr_t;   // text rom address
    typedef logic [11:0] page_num_t;   // relative page number
    typedef logic [4:0]  count_t;      // title, entry and line counters

    typedef struct packed {
        logic  valid;
        byte_t data;
    } dump_char_t;

    localparam byte_t line_end_char = 8'h0D;   // carriage return
    localparam byte_t space_char    = 8'h20;

    localparam int unsigned bytes_per_line = 16;
    localparam int unsigned boot_lines     = 30;
    localparam int unsigned user_lines     = 8;
    localparam int unsigned page_digits    = 3;   // 12-bit page, three hex digits

    // title strings, first character in the top byte
    localparam int unsigned boot_title_len  = 20;
    localparam int unsigned boot_title_base = 'h10;
    localparam logic [8*boot_title_len-1:0] boot_title = "BOOTLOADER PAGE DUMP";

    localparam int unsigned user_title_len  = 10;
    localparam int unsigned user_title_base = 'h50;
    localparam logic [8*user_title_len-1:0] user_title = "USER PAGE ";

    typedef enum logic [3:0] {
        ds_idle,       // wait for a dump request
        ds_title,      // walk the title string
        ds_rom_wait,   // rom address settles
        ds_rom_load,   // take rom data as next character
        ds_send,       // hold character until the writer takes it
        ds_page,       // page number digits, user dump only
        ds_head_end,   // line end after the heading
        ds_line,       // start of a data line
        ds_entry,      // one byte entry or end of line
        ds_hex_hi,     // high nibble lookup
        ds_hex_lo,     // low nibble lookup
        ds_space,      // separator after each byte
        ds_close,      // closing line end
        ds_release     // wait until both requests are released
    } dump_state_t;

endpackage

`default_nettype wire

// ==== ft_fifo_pkg.sv ====
`default_nettype none

package ft_fifo_pkg;

    // FT245 write side pins
    typedef struct packed {
        usb_dump_pkg::byte_t data;
        logic                wr_n;
    } ft_wr_t;

    localparam int unsigned wr_low_cycles = 2;   // wr_n low time in MCLK cycles

    typedef logic [1:0] wr_cnt_t;   // counts the wr_n low cycles

    typedef enum logic [1:0] {
        tx_idle,     // ready for the next character
        tx_wait,     // character held, wait for txe_n low
        tx_strobe,   // wr_n low
        tx_gap       // wr_n back high, one cycle before ready
    } fifo_tx_state_t;

endpackage

`default_nettype wire

// ==== bit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_buffer (
    input  wire logic                    MCLK,
    input  wire logic                    wr_en_n,
    input  wire usb_dump_pkg::bit_addr_t wr_addr,
    input  wire logic                    wr_bit,
    input  wire usb_dump_pkg::buf_addr_t rd_addr,
    output usb_dump_pkg::byte_t          rd_data
);

    usb_dump_pkg::byte_t     mem [1024];
    usb_dump_pkg::buf_addr_t wr_byte;   // byte holding the addressed bit
    logic [2:0]              wr_pos;    // bit position inside that byte

    // bit address 0 is bit 7 of byte 0
    assign wr_byte = wr_addr[12:3];
    assign wr_pos  = 3'd7 - wr_addr[2:0];

    always_ff @(posedge MCLK) begin
        if (!wr_en_n) begin
            mem[wr_byte][wr_pos] <= wr_bit;   // only the addressed bit changes
        end
    end

    always_ff @(posedge MCLK) begin
        rd_data <= mem[rd_addr];   // whole byte, one cycle later
    end

endmodule

`default_nettype wire

// ==== text_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_rom (
    input  wire logic                    MCLK,
    input  wire usb_dump_pkg::rom_addr_t addr,
    output usb_dump_pkg::byte_t          data
);

    // contents: hex digits at 0..15, the two titles at their bases, spaces elsewhere
    function automatic usb_dump_pkg::byte_t rom_byte(input usb_dump_pkg::rom_addr_t a);
        usb_dump_pkg::byte_t c;
        int unsigned         idx;
        c   = usb_dump_pkg::space_char;
        idx = 0;
        if (a < 7'd10) begin
            c = 8'h30 + 8'(a);   // '0'..'9'
        end else if (a < 7'd16) begin
            c = 8'h41 + 8'(a) - 8'd10;   // 'A'..'F'
        end else if (a >= usb_dump_pkg::boot_title_base &&
                     a < usb_dump_pkg::boot_title_base + usb_dump_pkg::boot_title_len) begin
            idx = a - usb_dump_pkg::boot_title_base;
            c   = usb_dump_pkg::boot_title[8*(usb_dump_pkg::boot_title_len-1-idx) +: 8];
        end else if (a >= usb_dump_pkg::user_title_base &&
                     a < usb_dump_pkg::user_title_base + usb_dump_pkg::user_title_len) begin
            idx = a - usb_dump_pkg::user_title_base;
            c   = usb_dump_pkg::user_title[8*(usb_dump_pkg::user_title_len-1-idx) +: 8];
        end
        return c;
    endfunction

    always_ff @(posedge MCLK) begin
        data <= rom_byte(addr);   // registered, one cycle latency
    end

endmodule

`default_nettype wire

// ==== dump_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
    input  wire logic                    MCLK,
    input  wire logic                    arst_n,
    input  wire logic                    send_boot_n,
    input  wire logic                    send_user_n,
    input  wire usb_dump_pkg::page_num_t rel_page,
    output usb_dump_pkg::rom_addr_t      rom_addr,
    input  wire usb_dump_pkg::byte_t     rom_data,
    output usb_dump_pkg::buf_addr_t      rd_addr,
    input  wire usb_dump_pkg::byte_t     rd_data,
    output usb_dump_pkg::dump_char_t     char_out,
    input  wire logic                    char_ready,
    output logic                         busy
);

    usb_dump_pkg::dump_state_t state;
    usb_dump_pkg::dump_state_t ret_state;   // where ds_send goes after the transfer
    logic                      user_mode;
    usb_dump_pkg::count_t      cnt;         // title chars, page digits or entries left
    usb_dump_pkg::count_t      line_cnt;    // data lines left
    usb_dump_pkg::rom_addr_t   rom_ptr;
    usb_dump_pkg::buf_addr_t   byte_addr;
    usb_dump_pkg::page_num_t   page_q;      // page number, shifted one digit per lookup
    usb_dump_pkg::dump_char_t  char_q;
    logic                      released;    // both requests high

    assign released = send_boot_n & send_user_n;
    assign rom_addr = rom_ptr;
    assign rd_addr  = byte_addr;
    assign char_out = char_q;
    assign busy     = (state != usb_dump_pkg::ds_idle) && (state != usb_dump_pkg::ds_release);

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= usb_dump_pkg::ds_idle;
            ret_state <= usb_dump_pkg::ds_idle;
            user_mode <= 1'b0;
            cnt       <= '0;
            line_cnt  <= '0;
            rom_ptr   <= '0;
            byte_addr <= '0;
            char_q    <= '0;
        end else begin
            unique case (state)
                usb_dump_pkg::ds_idle: begin
                    if (!send_boot_n || !send_user_n) begin
                        user_mode <= send_boot_n;   // boot wins when both are low
                        if (!send_boot_n) begin
                            rom_ptr <= usb_dump_pkg::rom_addr_t'(usb_dump_pkg::boot_title_base);
                            cnt     <= usb_dump_pkg::count_t'(usb_dump_pkg::boot_title_len);
                        end else begin
                            rom_ptr <= usb_dump_pkg::rom_addr_t'(usb_dump_pkg::user_title_base);
                            cnt     <= usb_dump_pkg::count_t'(usb_dump_pkg::user_title_len);
                        end
                        state <= usb_dump_pkg::ds_title;
                    end
                end
                usb_dump_pkg::ds_title: begin
                    if (cnt == '0) begin
                        if (user_mode) begin
                            cnt   <= usb_dump_pkg::count_t'(usb_dump_pkg::page_digits);
                            state <= usb_dump_pkg::ds_page;
                        end else begin
                            state <= usb_dump_pkg::ds_head_end;
                        end
                    end else begin
                        cnt       <= cnt - 1'b1;
                        ret_state <= usb_dump_pkg::ds_title;
                        state     <= usb_dump_pkg::ds_rom_wait;   // rom_ptr already on the char
                    end
                end
                usb_dump_pkg::ds_page: begin
                    if (cnt == '0) begin
                        state <= usb_dump_pkg::ds_head_end;
                    end else begin
                        rom_ptr   <= usb_dump_pkg::rom_addr_t'(page_q[11:8]);   // digit char
                        cnt       <= cnt - 1'b1;
                        ret_state <= usb_dump_pkg::ds_page;
                        state     <= usb_dump_pkg::ds_rom_wait;
                    end
                end
                usb_dump_pkg::ds_rom_wait: begin
                    state <= usb_dump_pkg::ds_rom_load;
                end
                usb_dump_pkg::ds_rom_load: begin
                    char_q  <= '{valid: 1'b1, data: rom_data};
                    rom_ptr <= rom_ptr + 7'd1;   // next title char
                    state   <= usb_dump_pkg::ds_send;
                end
                usb_dump_pkg::ds_send: begin
                    if (released) begin
                        char_q.valid <= 1'b0;   // dump aborted
                        state        <= usb_dump_pkg::ds_idle;
                    end else if (char_ready) begin
                        char_q.valid <= 1'b0;
                        state        <= ret_state;
                    end
                end
                usb_dump_pkg::ds_head_end: begin
                    char_q    <= '{valid: 1'b1, data: usb_dump_pkg::line_end_char};
                    line_cnt  <= user_mode ? usb_dump_pkg::count_t'(usb_dump_pkg::user_lines)
                                           : usb_dump_pkg::count_t'(usb_dump_pkg::boot_lines);
                    byte_addr <= '0;
                    ret_state <= usb_dump_pkg::ds_line;
                    state     <= usb_dump_pkg::ds_send;
                end
                usb_dump_pkg::ds_line: begin
                    if (line_cnt == '0) begin
                        state <= usb_dump_pkg::ds_close;
                    end else begin
                        cnt   <= usb_dump_pkg::count_t'(usb_dump_pkg::bytes_per_line);
                        state <= usb_dump_pkg::ds_entry;
                    end
                end
                usb_dump_pkg::ds_entry: begin
                    if (cnt == '0) begin
                        line_cnt  <= line_cnt - 1'b1;
                        char_q    <= '{valid: 1'b1, data: usb_dump_pkg::line_end_char};
                        ret_state <= usb_dump_pkg::ds_line;
                        state     <= usb_dump_pkg::ds_send;
                    end else begin
                        state <= usb_dump_pkg::ds_hex_hi;   // rd_data settled on byte_addr
                    end
                end
                usb_dump_pkg::ds_hex_hi: begin
                    rom_ptr   <= usb_dump_pkg::rom_addr_t'(rd_data[7:4]);
                    ret_state <= usb_dump_pkg::ds_hex_lo;
                    state     <= usb_dump_pkg::ds_rom_wait;
                end
                usb_dump_pkg::ds_hex_lo: begin
                    rom_ptr   <= usb_dump_pkg::rom_addr_t'(rd_data[3:0]);
                    byte_addr <= byte_addr + 10'd1;   // read ahead for the next entry
                    ret_state <= usb_dump_pkg::ds_space;
                    state     <= usb_dump_pkg::ds_rom_wait;
                end
                usb_dump_pkg::ds_space: begin
                    char_q    <= '{valid: 1'b1, data: usb_dump_pkg::space_char};
                    cnt       <= cnt - 1'b1;
                    ret_state <= usb_dump_pkg::ds_entry;
                    state     <= usb_dump_pkg::ds_send;
                end
                usb_dump_pkg::ds_close: begin
                    char_q    <= '{valid: 1'b1, data: usb_dump_pkg::line_end_char};
                    ret_state <= usb_dump_pkg::ds_release;
                    state     <= usb_dump_pkg::ds_send;
                end
                usb_dump_pkg::ds_release: begin
                    if (released) begin
                        state <= usb_dump_pkg::ds_idle;
                    end
                end
                default: begin
                    state <= usb_dump_pkg::ds_idle;
                end
            endcase
        end
    end

    // page number is captured while idle and shifted as digits are looked up
    always_ff @(posedge MCLK) begin
        if (state == usb_dump_pkg::ds_idle) begin
            page_q <= rel_page;
        end else if (state == usb_dump_pkg::ds_page && cnt != '0) begin
            page_q <= page_q << 4;
        end
    end

endmodule

`default_nettype wire

// ==== fifo_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_writer (
    input  wire logic                     MCLK,
    input  wire logic                     arst_n,
    input  wire usb_dump_pkg::dump_char_t char_in,
    output logic                          char_ready,
    input  wire logic                     abort,
    input  wire logic                     txe_n,
    output ft_fifo_pkg::ft_wr_t           ft_out
);

    ft_fifo_pkg::fifo_tx_state_t state;
    ft_fifo_pkg::wr_cnt_t        wr_cnt;

    assign char_ready = (state == ft_fifo_pkg::tx_idle);

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ft_fifo_pkg::tx_idle;
            wr_cnt <= '0;
            ft_out <= '{data: 8'h00, wr_n: 1'b1};
        end else begin
            unique case (state)
                ft_fifo_pkg::tx_idle: begin
                    if (char_in.valid) begin
                        ft_out.data <= char_in.data;   // accepted char held on the pins
                        state       <= ft_fifo_pkg::tx_wait;
                    end
                end
                ft_fifo_pkg::tx_wait: begin
                    if (abort) begin
                        state <= ft_fifo_pkg::tx_idle;   // drop it, no strobe
                    end else if (!txe_n) begin
                        ft_out.wr_n <= 1'b0;
                        wr_cnt      <= '0;
                        state       <= ft_fifo_pkg::tx_strobe;
                    end
                end
                ft_fifo_pkg::tx_strobe: begin
                    if (wr_cnt == ft_fifo_pkg::wr_cnt_t'(ft_fifo_pkg::wr_low_cycles - 1)) begin
                        ft_out.wr_n <= 1'b1;   // rising edge writes the byte
                        state       <= ft_fifo_pkg::tx_gap;
                    end else begin
                        wr_cnt <= wr_cnt + 2'd1;
                    end
                end
                ft_fifo_pkg::tx_gap: begin
                    state <= ft_fifo_pkg::tx_idle;
                end
                default: begin
                    state <= ft_fifo_pkg::tx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== usb_dump_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_dump_top (
    input  wire logic                    MCLK,
    input  wire logic                    arst_n,
    input  wire logic                    buf_wr_en_n,
    input  wire usb_dump_pkg::bit_addr_t buf_wr_addr,
    input  wire logic                    buf_wr_bit,
    input  wire logic                    send_boot_n,
    input  wire logic                    send_user_n,
    input  wire usb_dump_pkg::page_num_t rel_page,
    input  wire logic                    txe_n,
    output ft_fifo_pkg::ft_wr_t          ft_out,
    output logic                         busy
);

    usb_dump_pkg::rom_addr_t  rom_addr;
    usb_dump_pkg::byte_t      rom_data;
    usb_dump_pkg::buf_addr_t  rd_addr;
    usb_dump_pkg::byte_t      rd_data;
    usb_dump_pkg::dump_char_t dump_char;
    logic                     char_ready;
    logic                     abort;

    assign abort = send_boot_n & send_user_n;   // both requests released

    bit_buffer u_bit_buffer (
        .MCLK    (MCLK),
        .wr_en_n (buf_wr_en_n),
        .wr_addr (buf_wr_addr),
        .wr_bit  (buf_wr_bit),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    text_rom u_text_rom (
        .MCLK (MCLK),
        .addr (rom_addr),
        .data (rom_data)
    );

    dump_sequencer u_dump_sequencer (
        .MCLK        (MCLK),
        .arst_n      (arst_n),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .rel_page    (rel_page),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .char_out    (dump_char),
        .char_ready  (char_ready),
        .busy        (busy)
    );

    fifo_writer u_fifo_writer (
        .MCLK       (MCLK),
        .arst_n     (arst_n),
        .char_in    (dump_char),
        .char_ready (char_ready),
        .abort      (abort),
        .txe_n      (txe_n),
        .ft_out     (ft_out)
    );

endmodule

`default_nettype wire

// ==== tb_usb_dump.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usb_dump;

    localparam int max_tests     = 16;
    localparam int settle_cycles = 200;   // last byte may still sit in the writer
    localparam int abort_after   = 40;    // bytes sent before the requests are released

    logic                    MCLK;
    logic                    arst_n;
    logic                    buf_wr_en_n;
    usb_dump_pkg::bit_addr_t buf_wr_addr;
    logic                    buf_wr_bit;
    logic                    send_boot_n;
    logic                    send_user_n;
    usb_dump_pkg::page_num_t rel_page;
    logic                    txe_n;
    ft_fifo_pkg::ft_wr_t     ft_out;
    logic                    busy;

    logic [8*16-1:0] t_name  [max_tests];
    logic [8*16-1:0] t_mode  [max_tests];
    logic [11:0]     t_page  [max_tests];
    logic [7:0]      t_start [max_tests];
    logic [7:0]      t_step  [max_tests];
    int              t_stall [max_tests];
    int              t_count [max_tests];
    logic [15:0]     t_sum   [max_tests];
    int              n_tests;

    logic [7:0]      exp_q[$];          // expected bytes of the current dump
    logic [8*16-1:0] cur_name;
    int              stall_pct  = 0;
    int              cap_count  = 0;
    logic [15:0]     cap_sum    = '0;
    int              err_count  = 0;
    int              shown      = 0;    // mismatch lines printed in this test
    int              wd_cycles  = 0;
    integer          seed       = 89011;
    int unsigned     rnd;
    logic            prev_wr_n  = 1'b1;
    logic            prev_txe_n = 1'b1;
    int              low_len    = 0;

    usb_dump_top u_usb_dump_top (
        .MCLK        (MCLK),
        .arst_n      (arst_n),
        .buf_wr_en_n (buf_wr_en_n),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_bit  (buf_wr_bit),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .rel_page    (rel_page),
        .txe_n       (txe_n),
        .ft_out      (ft_out),
        .busy        (busy)
    );

    initial begin
        MCLK = 1'b0;
        forever #2 MCLK = ~MCLK;
    end

    // FIFO full flag, high on stall_pct percent of the cycles
    always @(posedge MCLK) begin
        rnd = $random(seed);
        txe_n <= (int'(rnd % 100) < stall_pct) ? 1'b1 : 1'b0;
    end

    function automatic logic [7:0] fill_byte(input int i, input logic [7:0] start,
                                             input logic [7:0] step);
        return start + 8'(i * step);
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + 8'(n);
        end
        return 8'h37 + 8'(n);   // 'A' for 10
    endfunction

    task automatic capture_byte(input logic [7:0] d);
        if (cap_count >= exp_q.size()) begin
            err_count++;
            $display("%0s: extra byte %h after the end of the dump", cur_name, d);
        end else if (d !== exp_q[cap_count]) begin
            err_count++;
            if (shown < 10) begin
                $display("MISMATCH %0s byte %0d expected %h actual %h",
                         cur_name, cap_count, exp_q[cap_count], d);
            end
            shown++;
        end
        cap_sum   = cap_sum + 16'(d);
        cap_count = cap_count + 1;
    endtask

    // outputs are settled at the falling edge
    always @(negedge MCLK) begin
        if (arst_n) begin
            if (prev_wr_n && !ft_out.wr_n && prev_txe_n) begin
                err_count++;
                $display("%0s: wr_n went low although txe_n was high", cur_name);
            end
            if (!ft_out.wr_n) begin
                low_len++;
            end else if (!prev_wr_n) begin   // wr_n rising edge writes the byte
                if (low_len != 2) begin
                    err_count++;
                    $display("MISMATCH %0s wr_n low cycles expected 2 actual %0d",
                             cur_name, low_len);
                end
                capture_byte(ft_out.data);
                low_len = 0;
            end
        end
        prev_wr_n  = ft_out.wr_n;
        prev_txe_n = txe_n;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge MCLK);
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("sim failed");
        $finish;
    end

    task automatic read_trace(output logic ok);
        int              fd;
        int              r;
        logic [8*16-1:0] tok;
        logic [8*96-1:0] skip;
        n_tests = 0;
        fd      = $fopen("usb_dump_trace.txt", "r");
        ok      = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && n_tests < max_tests) begin
                r = $fscanf(fd, "%s", tok);
                if (r == 1 && tok == "#") begin
                    r = $fgets(skip, fd);   // column notes
                end else if (r == 1) begin
                    r = $fscanf(fd, "%s %h %h %h %d %d %h", t_mode[n_tests],
                                t_page[n_tests], t_start[n_tests], t_step[n_tests],
                                t_stall[n_tests], t_count[n_tests], t_sum[n_tests]);
                    t_name[n_tests] = tok;
                    if (r == 7) begin
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_buffer(input logic [7:0] start, input logic [7:0] step);
        logic [7:0] b;
        for (int i = 0; i < 1024; i++) begin
            b = fill_byte(i, start, step);
            for (int k = 0; k < 8; k++) begin
                @(posedge MCLK);
                buf_wr_en_n <= 1'b0;
                buf_wr_addr <= {10'(i), 3'(k)};
                buf_wr_bit  <= b[7-k];   // msb first
            end
        end
        @(posedge MCLK);
        buf_wr_en_n <= 1'b1;
    endtask

    task automatic build_expected(input logic is_boot, input logic [11:0] page,
                                  input logic [7:0] start, input logic [7:0] step);
        string      title;
        int         n_lines;
        logic [7:0] b;
        exp_q.delete();
        if (is_boot) begin
            title   = "BOOTLOADER PAGE DUMP";
            n_lines = 30;
        end else begin
            title   = "USER PAGE ";
            n_lines = 8;
        end
        for (int i = 0; i < title.len(); i++) begin
            exp_q.push_back(title[i]);
        end
        if (!is_boot) begin
            exp_q.push_back(hex_char(page[11:8]));
            exp_q.push_back(hex_char(page[7:4]));
            exp_q.push_back(hex_char(page[3:0]));
        end
        exp_q.push_back(8'h0D);
        for (int l = 0; l < n_lines; l++) begin
            for (int e = 0; e < 16; e++) begin
                b = fill_byte(l * 16 + e, start, step);
                exp_q.push_back(hex_char(b[7:4]));
                exp_q.push_back(hex_char(b[3:0]));
                exp_q.push_back(8'h20);
            end
            exp_q.push_back(8'h0D);
        end
        exp_q.push_back(8'h0D);   // closing line end
    endtask

    task automatic wait_for_busy(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(negedge MCLK);
            n++;
        end
        ok = (busy === level);
    endtask

    task automatic abort_dump(input int t);
        logic ok;
        int   n;
        int   at_release;
        cap_count = 0;
        cap_sum   = '0;
        @(posedge MCLK);
        send_user_n <= 1'b0;
        n = 0;
        while (cap_count < abort_after && n < abort_after * (t_stall[t] / 10 + 8)) begin
            @(negedge MCLK);
            n++;
        end
        if (cap_count < abort_after) begin
            err_count++;
            $display("%0s: only %0d bytes arrived before the abort", cur_name, cap_count);
        end
        @(posedge MCLK);
        send_boot_n <= 1'b1;
        send_user_n <= 1'b1;
        at_release = cap_count;
        wait_for_busy(1'b0, 100, ok);
        if (!ok) begin
            err_count++;
            $display("%0s: busy stayed high after both requests were released", cur_name);
        end
        repeat (50) @(posedge MCLK);   // only a strobe in progress may still complete
        if (cap_count > at_release + 1) begin
            err_count++;
            $display("MISMATCH %0s bytes after the release expected at most %0d actual %0d",
                     cur_name, at_release + 1, cap_count);
        end
    endtask

    task automatic run_dump(input logic is_boot, input int t);
        logic ok;
        int   n;
        cap_count = 0;
        cap_sum   = '0;
        @(posedge MCLK);
        send_boot_n <= !is_boot;
        send_user_n <= is_boot;
        wait_for_busy(1'b1, 20, ok);
        if (!ok) begin
            err_count++;
            $display("%0s: busy did not rise after the request", cur_name);
        end
        wait_for_busy(1'b0, t_count[t] * (t_stall[t] / 10 + 8), ok);
        if (!ok) begin
            err_count++;
            $display("%0s: busy did not fall within the expected dump time", cur_name);
        end
        n = 0;
        while (cap_count < t_count[t] && n < settle_cycles) begin
            @(negedge MCLK);
            n++;
        end
        @(posedge MCLK);
        send_boot_n <= 1'b1;
        send_user_n <= 1'b1;
        repeat (4) @(posedge MCLK);
    endtask

    task automatic run_test(input int t);
        logic is_boot;
        cur_name = t_name[t];
        shown    = 0;
        is_boot  = (t_mode[t] == "boot");
        load_buffer(t_start[t], t_step[t]);
        build_expected(is_boot, t_page[t], t_start[t], t_step[t]);
        stall_pct <= t_stall[t];
        rel_page  <= t_page[t];
        if (t_mode[t] == "abort") begin
            abort_dump(t);   // then a full user dump
        end
        run_dump(is_boot, t);
        if (cap_count != t_count[t]) begin
            err_count++;
            $display("MISMATCH %0s byte count expected %0d actual %0d",
                     cur_name, t_count[t], cap_count);
        end
        if (cap_sum !== t_sum[t]) begin
            err_count++;
            $display("MISMATCH %0s byte sum expected %h actual %h", cur_name, t_sum[t], cap_sum);
        end
    endtask

    initial begin
        logic ok;
        int   errs_before;
        int   n_fail;
        int   wd;
        arst_n      = 1'b0;
        buf_wr_en_n = 1'b1;
        buf_wr_addr = '0;
        buf_wr_bit  = 1'b0;
        send_boot_n = 1'b1;
        send_user_n = 1'b1;
        rel_page    = '0;
        txe_n       = 1'b1;
        n_fail      = 0;
        read_trace(ok);
        if (!ok) begin
            err_count++;
            $display("could not open usb_dump_trace.txt");
        end else begin
            wd = 200;
            for (int t = 0; t < n_tests; t++) begin
                wd += 8192 + 2 * settle_cycles + 50 +
                      t_count[t] * (t_stall[t] / 10 + 8) * ((t_mode[t] == "abort") ? 2 : 1);
            end
            wd_cycles = wd;
            repeat (5) @(posedge MCLK);
            arst_n <= 1'b1;
            for (int t = 0; t < n_tests; t++) begin
                errs_before = err_count;
                run_test(t);
                if (err_count == errs_before) begin
                    $display("test %0s: ok, %0d bytes, sum %h", t_name[t], cap_count, cap_sum);
                end else begin
                    n_fail++;
                    $display("test %0s: FAIL, %0d errors", t_name[t], err_count - errs_before);
                end
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, n_tests - n_fail, n_fail, err_count);
        if (err_count == 0 && n_tests > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== usb_dump_trace.txt ====
# name mode page start step stall bytes sum
# page, start, step and sum in hex, stall in percent, fill byte i = start + i * step
boot_ramp    boot  000 00 01  0 1492 1BAA
boot_offset  boot  000 80 01  0 1492 1D8A
user_page    user  1A7 00 01  0  407 4A97
boot_stall   boot  000 00 01 50 1492 1BAA
user_stall   user  1A7 00 01 25  407 4A97
abort_redo   abort 3C5 00 01  0  407 4A99

// ==== all.f ====
usb_dump_pkg.sv
ft_fifo_pkg.sv
bit_buffer.sv
text_rom.sv
dump_sequencer.sv
fifo_writer.sv
usb_dump_top.sv
tb_usb_dump.sv

// ==== Bender.yml ====
package:
  name: usb_dump

sources:
  - usb_dump_pkg.sv
  - ft_fifo_pkg.sv
  - bit_buffer.sv
  - text_rom.sv
  - dump_sequencer.sv
  - fifo_writer.sv
  - usb_dump_top.sv
  - target: test
    files:
      - tb_usb_dump.sv
